/* common/pkt_lkp_pkg.sv */
package pkt_lkp_pkg;

    // ------------------------------------------------------------
    // widths and depths
    // ------------------------------------------------------------
    localparam int LKP_INFO_W     = 20;
    localparam int ODR_ID_W       = 3;
    localparam int PAYLOAD_W      = 64;
    localparam int REQ_ID_W       = 10;
    localparam int ROB_DEPTH      = 8;
    localparam int ROB_IDX_W      = 3;
    localparam int LKP_FIFO_DEPTH = 4;
    // fifo slot index width
    localparam int LKP_FIFO_IDX_W = 2;

    // ------------------------------------------------------------
    // plain vector types
    // ------------------------------------------------------------
    // lookup info toward A and result back from A
    typedef logic [LKP_INFO_W-1:0] lkp_info_t;
    typedef logic [ODR_ID_W-1:0]   odr_id_t;
    typedef logic [PAYLOAD_W-1:0]  payload_t;
    typedef logic [REQ_ID_W-1:0]   req_id_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;

    // ------------------------------------------------------------
    // packed structs
    // ------------------------------------------------------------
    // packet fields from B without the payload
    typedef struct packed {
        logic      lkp_en;
        lkp_info_t lkp_info;
        odr_id_t   odr_id;
        logic      so;
    } pkt_meta_t;

    // one request toward A
    typedef struct packed {
        lkp_info_t info;
        req_id_t   req_id;
    } lkp_req_t;

    // packet as presented to D
    typedef struct packed {
        lkp_info_t rslt;
        odr_id_t   odr_id;
        logic      so;
        payload_t  payload;
    } out_pkt_t;

endpackage

/* rtl/lkp_req_fifo.sv */
`timescale 1ns/1ps

module lkp_req_fifo
    import pkt_lkp_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  logic     push_i,
    input  lkp_req_t req_i,
    input  logic     lkp_rdy_i,
    output logic     full_o,
    output logic     lkp_vld_o,
    output lkp_req_t lkp_req_o
);

    // ------------------------------------------------------------
    // storage and pointers
    // ------------------------------------------------------------
    lkp_req_t                  mem_q [LKP_FIFO_DEPTH];
    // msb of each pointer is the wrap bit
    logic [LKP_FIFO_IDX_W:0]   wr_ptr_q;
    logic [LKP_FIFO_IDX_W:0]   rd_ptr_q;
    logic [LKP_FIFO_IDX_W-1:0] wr_idx;
    logic [LKP_FIFO_IDX_W-1:0] rd_idx;
    logic                      empty;
    logic                      pop;

    assign wr_idx = wr_ptr_q[LKP_FIFO_IDX_W-1:0];
    assign rd_idx = rd_ptr_q[LKP_FIFO_IDX_W-1:0];

    assign empty  = (wr_ptr_q == rd_ptr_q);
    assign full_o = (wr_idx == rd_idx) &&
                    (wr_ptr_q[LKP_FIFO_IDX_W] != rd_ptr_q[LKP_FIFO_IDX_W]);

    // oldest entry goes to A
    assign lkp_vld_o = !empty;
    assign lkp_req_o = mem_q[rd_idx];
    assign pop       = lkp_vld_o && lkp_rdy_i;

    // ------------------------------------------------------------
    // pointer update
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            if (push_i && !full_o)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push_i && !full_o)
            mem_q[wr_idx] <= req_i;
    end

endmodule

/* rob/payload_ram.sv */
`timescale 1ns/1ps

module payload_ram
    import pkt_lkp_pkg::*;
(
    input  logic     clk,
    input  logic     wr_i,
    input  rob_idx_t wr_idx_i,
    input  payload_t wr_data_i,
    input  rob_idx_t rd_idx_i,
    output payload_t rd_data_o
);

    // one payload per rob slot
    payload_t mem_q [ROB_DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr_i)
            mem_q[wr_idx_i] <= wr_data_i;
    end

    // registered read of the head slot
    always_ff @(posedge clk)
    begin
        rd_data_o <= mem_q[rd_idx_i];
    end

endmodule

/* rob/rob_ctrl.sv */
`timescale 1ns/1ps

module rob_ctrl
    import pkt_lkp_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      pkt_vld_i,
    input  pkt_meta_t pkt_meta_i,
    input  logic      lkp_fifo_full_i,
    input  logic      rsp_vld_i,
    input  req_id_t   rsp_id_i,
    input  lkp_info_t rsp_rslt_i,
    input  logic      egress_free_i,
    output logic      pkt_rdy_o,
    output logic      lkp_push_o,
    output lkp_req_t  lkp_req_o,
    output logic      ram_wr_o,
    output rob_idx_t  ram_wr_idx_o,
    output rob_idx_t  ram_rd_idx_o,
    output logic      retire_o,
    output lkp_info_t retire_rslt_o,
    output pkt_meta_t retire_meta_o
);

    // ------------------------------------------------------------
    // slot state
    // ------------------------------------------------------------
    // pointers carry a wrap bit above the slot index
    logic [ROB_IDX_W:0]   head_q;
    logic [ROB_IDX_W:0]   tail_q;
    logic [ROB_DEPTH-1:0] done_q;
    lkp_info_t            rslt_q [ROB_DEPTH];
    pkt_meta_t            meta_q [ROB_DEPTH];

    rob_idx_t head_idx;
    rob_idx_t tail_idx;
    rob_idx_t rsp_idx;
    logic     rob_empty;
    logic     rob_full;
    logic     accept;
    logic     retire_now;

    assign head_idx = head_q[ROB_IDX_W-1:0];
    assign tail_idx = tail_q[ROB_IDX_W-1:0];
    // request id is the slot index, so its low bits pick the slot
    assign rsp_idx  = rsp_id_i[ROB_IDX_W-1:0];

    assign rob_empty = (head_q == tail_q);
    assign rob_full  = (head_idx == tail_idx) && (head_q[ROB_IDX_W] != tail_q[ROB_IDX_W]);

    // ------------------------------------------------------------
    // allocation at the tail
    // ------------------------------------------------------------
    assign pkt_rdy_o = !rob_full && !lkp_fifo_full_i;
    assign accept    = pkt_vld_i && pkt_rdy_o;

    assign lkp_push_o       = accept && pkt_meta_i.lkp_en;
    assign lkp_req_o.info   = pkt_meta_i.lkp_info;
    assign lkp_req_o.req_id = {{(REQ_ID_W-ROB_IDX_W){1'b0}}, tail_idx};

    assign ram_wr_o     = accept;
    assign ram_wr_idx_o = tail_idx;

    // head must be complete and the output stage empty
    assign retire_now   = !rob_empty && done_q[head_idx] && egress_free_i;
    assign ram_rd_idx_o = head_idx;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            head_q   <= '0;
            tail_q   <= '0;
            done_q   <= '0;
            retire_o <= 1'b0;
        end
        else
        begin
            retire_o <= retire_now;
            if (retire_now)
            begin
                done_q[head_idx] <= 1'b0;
                head_q           <= head_q + 1'b1;
            end
            // bypass packets are complete on arrival
            if (accept)
            begin
                done_q[tail_idx] <= !pkt_meta_i.lkp_en;
                tail_q           <= tail_q + 1'b1;
            end
            if (rsp_vld_i)
                done_q[rsp_idx] <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // per-slot result and meta
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            meta_q[tail_idx] <= pkt_meta_i;
            rslt_q[tail_idx] <= '0;
        end
        if (rsp_vld_i)
            rslt_q[rsp_idx] <= rsp_rslt_i;
    end

    // registered alongside the ram read
    always_ff @(posedge clk)
    begin
        if (retire_now)
        begin
            retire_rslt_o <= rslt_q[head_idx];
            retire_meta_o <= meta_q[head_idx];
        end
    end

endmodule

/* rtl/pkt_egress.sv */
`timescale 1ns/1ps

module pkt_egress
    import pkt_lkp_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      retire_i,
    input  lkp_info_t rslt_i,
    input  pkt_meta_t meta_i,
    input  payload_t  payload_i,
    input  logic      d_rdy_i,
    output logic      free_o,
    output logic      d_vld_o,
    output out_pkt_t  d_pkt_o
);

    // ------------------------------------------------------------
    // hold state
    // ------------------------------------------------------------
    // busy while a pulse is arriving or a packet waits for D
    assign free_o = !retire_i && !d_vld_o;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            d_vld_o <= 1'b0;
        end
        else
        begin
            if (retire_i)
                d_vld_o <= 1'b1;
            else if (d_vld_o && d_rdy_i)
                d_vld_o <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // packet register
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (retire_i)
        begin
            d_pkt_o.rslt    <= rslt_i;
            d_pkt_o.odr_id  <= meta_i.odr_id;
            d_pkt_o.so      <= meta_i.so;
            d_pkt_o.payload <= payload_i;
        end
    end

endmodule

/* rtl/pkt_lkp_top.sv */
`timescale 1ns/1ps

module pkt_lkp_top
    import pkt_lkp_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,

    // B side
    input  logic      b2c_pkt_vld_i,
    input  logic      b2c_pkt_lkp_en_i,
    input  lkp_info_t b2c_pkt_lkp_info_i,
    input  odr_id_t   b2c_pkt_odr_id_i,
    input  logic      b2c_pkt_so_i,
    input  payload_t  b2c_pkt_payload_i,
    output logic      c2b_pkt_rdy_o,

    // A side
    output logic      c2a_lkp_vld_o,
    output lkp_info_t c2a_lkp_info_o,
    output req_id_t   c2a_lkp_req_id_o,
    input  logic      a2c_lkp_rdy_i,
    input  logic      a2c_lkp_rsp_vld_i,
    input  req_id_t   a2c_lkp_rsp_id_i,
    input  lkp_info_t a2c_lkp_rslt_i,

    // D side
    output logic      c2d_pkt_vld_o,
    output lkp_info_t c2d_pkt_lkp_rslt_o,
    output odr_id_t   c2d_pkt_odr_id_o,
    output logic      c2d_pkt_so_o,
    output payload_t  c2d_pkt_payload_o,
    input  logic      d2c_pkt_rdy_i
);

    pkt_meta_t b_meta;
    logic      lkp_push;
    lkp_req_t  lkp_push_req;
    lkp_req_t  lkp_head_req;
    logic      lkp_fifo_full;
    logic      ram_wr;
    rob_idx_t  ram_wr_idx;
    rob_idx_t  ram_rd_idx;
    payload_t  ram_rd_data;
    logic      retire;
    lkp_info_t retire_rslt;
    pkt_meta_t retire_meta;
    logic      egress_free;
    out_pkt_t  d_pkt;

    assign b_meta = '{lkp_en:   b2c_pkt_lkp_en_i,
                      lkp_info: b2c_pkt_lkp_info_i,
                      odr_id:   b2c_pkt_odr_id_i,
                      so:       b2c_pkt_so_i};

    rob_ctrl u_rob_ctrl (
        .clk             (clk),
        .rst_i           (rst_i),
        .pkt_vld_i       (b2c_pkt_vld_i),
        .pkt_meta_i      (b_meta),
        .lkp_fifo_full_i (lkp_fifo_full),
        .rsp_vld_i       (a2c_lkp_rsp_vld_i),
        .rsp_id_i        (a2c_lkp_rsp_id_i),
        .rsp_rslt_i      (a2c_lkp_rslt_i),
        .egress_free_i   (egress_free),
        .pkt_rdy_o       (c2b_pkt_rdy_o),
        .lkp_push_o      (lkp_push),
        .lkp_req_o       (lkp_push_req),
        .ram_wr_o        (ram_wr),
        .ram_wr_idx_o    (ram_wr_idx),
        .ram_rd_idx_o    (ram_rd_idx),
        .retire_o        (retire),
        .retire_rslt_o   (retire_rslt),
        .retire_meta_o   (retire_meta)
    );

    lkp_req_fifo u_lkp_req_fifo (
        .clk       (clk),
        .rst_i     (rst_i),
        .push_i    (lkp_push),
        .req_i     (lkp_push_req),
        .lkp_rdy_i (a2c_lkp_rdy_i),
        .full_o    (lkp_fifo_full),
        .lkp_vld_o (c2a_lkp_vld_o),
        .lkp_req_o (lkp_head_req)
    );

    assign c2a_lkp_info_o   = lkp_head_req.info;
    assign c2a_lkp_req_id_o = lkp_head_req.req_id;

    payload_ram u_payload_ram (
        .clk       (clk),
        .wr_i      (ram_wr),
        .wr_idx_i  (ram_wr_idx),
        .wr_data_i (b2c_pkt_payload_i),
        .rd_idx_i  (ram_rd_idx),
        .rd_data_o (ram_rd_data)
    );

    pkt_egress u_pkt_egress (
        .clk       (clk),
        .rst_i     (rst_i),
        .retire_i  (retire),
        .rslt_i    (retire_rslt),
        .meta_i    (retire_meta),
        .payload_i (ram_rd_data),
        .d_rdy_i   (d2c_pkt_rdy_i),
        .free_o    (egress_free),
        .d_vld_o   (c2d_pkt_vld_o),
        .d_pkt_o   (d_pkt)
    );

    // unpack toward D
    assign c2d_pkt_lkp_rslt_o = d_pkt.rslt;
    assign c2d_pkt_odr_id_o   = d_pkt.odr_id;
    assign c2d_pkt_so_o       = d_pkt.so;
    assign c2d_pkt_payload_o  = d_pkt.payload;

endmodule

/* verif/tb_pkt_lkp.sv */
`timescale 1ns/1ps

module tb_pkt_lkp
    import pkt_lkp_pkg::*;
();

    localparam int        WAIT_LIMIT = 400;
    localparam int        NUM_ROWS   = 12;
    // A answers with the request info scrambled by this key
    localparam lkp_info_t RSLT_KEY   = 20'h5a3c6;

    typedef struct packed {
        logic      lkp_en;
        lkp_info_t info;
        odr_id_t   odr_id;
        logic      so;
        payload_t  payload;
    } stim_t;

    // ------------------------------------------------------------
    // stimulus table with one packet per row
    // ------------------------------------------------------------
    // each row holds lookup enable, info, order id, so and payload
    stim_t stim_tbl [NUM_ROWS] = '{
        '{1'b0, 20'h00011, 3'd0, 1'b0, 64'h0123_4567_89ab_cdef},
        '{1'b1, 20'h1a2b3, 3'd1, 1'b1, 64'hfedc_ba98_7654_3210},
        '{1'b1, 20'h0f00d, 3'd2, 1'b0, 64'h1111_2222_3333_4444},
        '{1'b0, 20'h7777a, 3'd3, 1'b1, 64'h5555_6666_7777_8888},
        '{1'b1, 20'hc0ffe, 3'd4, 1'b0, 64'hdead_beef_0000_0001},
        '{1'b1, 20'h3d3d3, 3'd5, 1'b1, 64'h0bad_f00d_cafe_0002},
        '{1'b0, 20'h12345, 3'd6, 1'b0, 64'ha5a5_5a5a_a5a5_5a5a},
        '{1'b1, 20'hfffff, 3'd7, 1'b1, 64'h8000_0000_0000_0007},
        '{1'b1, 20'h00000, 3'd0, 1'b0, 64'h0000_0000_ffff_0008},
        '{1'b0, 20'habcde, 3'd1, 1'b1, 64'h0f0f_0f0f_f0f0_f0f0},
        '{1'b1, 20'h54321, 3'd2, 1'b0, 64'h1357_9bdf_2468_ace0},
        '{1'b1, 20'h9e3a1, 3'd3, 1'b1, 64'hc3c3_3c3c_0000_000b}
    };

    logic      clk;
    logic      rst_i              = 1'b1;
    logic      b2c_pkt_vld_i      = 1'b0;
    logic      b2c_pkt_lkp_en_i   = 1'b0;
    lkp_info_t b2c_pkt_lkp_info_i = '0;
    odr_id_t   b2c_pkt_odr_id_i   = '0;
    logic      b2c_pkt_so_i       = 1'b0;
    payload_t  b2c_pkt_payload_i  = '0;
    logic      c2b_pkt_rdy_o;
    logic      c2a_lkp_vld_o;
    lkp_info_t c2a_lkp_info_o;
    req_id_t   c2a_lkp_req_id_o;
    logic      a2c_lkp_rdy_i      = 1'b1;
    logic      a2c_lkp_rsp_vld_i  = 1'b0;
    req_id_t   a2c_lkp_rsp_id_i   = '0;
    lkp_info_t a2c_lkp_rslt_i     = '0;
    logic      c2d_pkt_vld_o;
    lkp_info_t c2d_pkt_lkp_rslt_o;
    odr_id_t   c2d_pkt_odr_id_o;
    logic      c2d_pkt_so_o;
    payload_t  c2d_pkt_payload_o;
    logic      d2c_pkt_rdy_i      = 1'b1;

    // model controls set by the test sequence
    logic a_rdy_hold = 1'b0;
    logic a_rdy_rand = 1'b0;
    logic a_rsp_en   = 1'b1;
    logic d_rdy_rand = 1'b0;

    int seed      = 8364;
    int err_cnt   = 0;
    int check_cnt = 0;
    int test_cnt  = 0;
    int fail_cnt  = 0;
    int err_mark  = 0;
    int a_req_cnt = 0;
    int d_cnt     = 0;

    out_pkt_t  exp_q [$];
    lkp_info_t pend_info [$];
    req_id_t   pend_id [$];
    int        pend_dly [$];
    logic      a_held = 1'b0;
    lkp_req_t  a_held_req;
    logic      d_held = 1'b0;
    out_pkt_t  d_held_pkt;

    pkt_lkp_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_rslt(input lkp_info_t got, input lkp_info_t exp_val, input string what);
        check_cnt++;
        if (got !== exp_val)
        begin
            err_cnt++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp_val);
        end
    endtask

    task automatic check_odr(input odr_id_t got, input odr_id_t exp_val, input string what);
        check_cnt++;
        if (got !== exp_val)
        begin
            err_cnt++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp_val);
        end
    endtask

    task automatic check_payload(input payload_t got, input payload_t exp_val, input string what);
        check_cnt++;
        if (got !== exp_val)
        begin
            err_cnt++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp_val);
        end
    endtask

    task automatic check_req_id(input req_id_t got, input req_id_t exp_val, input string what);
        check_cnt++;
        if (got !== exp_val)
        begin
            err_cnt++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp_val);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp_val, input string what);
        check_cnt++;
        if (got !== exp_val)
        begin
            err_cnt++;
            $display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp_val);
        end
    endtask

    task automatic compare_pkt(input out_pkt_t got, input out_pkt_t exp_pkt);
        check_rslt(got.rslt, exp_pkt.rslt, "result");
        check_odr(got.odr_id, exp_pkt.odr_id, "order id");
        check_flag(got.so, exp_pkt.so, "so flag");
        check_payload(got.payload, exp_pkt.payload, "payload");
    endtask

    // ------------------------------------------------------------
    // B driver and sequencing helpers
    // ------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic send_pkt(input stim_t row);
        int       wait_cnt;
        out_pkt_t exp_pkt;
        wait_cnt        = 0;
        exp_pkt.rslt    = row.lkp_en ? (row.info ^ RSLT_KEY) : '0;
        exp_pkt.odr_id  = row.odr_id;
        exp_pkt.so      = row.so;
        exp_pkt.payload = row.payload;
        b2c_pkt_vld_i      = 1'b1;
        b2c_pkt_lkp_en_i   = row.lkp_en;
        b2c_pkt_lkp_info_i = row.info;
        b2c_pkt_odr_id_i   = row.odr_id;
        b2c_pkt_so_i       = row.so;
        b2c_pkt_payload_i  = row.payload;
        @(negedge clk);
        while (!c2b_pkt_rdy_o && wait_cnt < WAIT_LIMIT)
        begin
            wait_cnt++;
            @(negedge clk);
        end
        if (c2b_pkt_rdy_o)
            exp_q.push_back(exp_pkt);
        else
        begin
            err_cnt++;
            $display("timeout: B never accepted the packet with order id %0d", row.odr_id);
        end
        next_cycle();
        b2c_pkt_vld_i = 1'b0;
    endtask

    // sel 0 takes bypass rows, 1 lookup rows, 2 every row
    task automatic run_rows(input int sel, input int max_pkts);
        int sent;
        sent = 0;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            if (sent < max_pkts && (sel == 2 || int'(stim_tbl[i].lkp_en) == sel))
            begin
                send_pkt(stim_tbl[i]);
                sent++;
            end
        end
    endtask

    task automatic wait_drain();
        int wait_cnt;
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < WAIT_LIMIT)
        begin
            next_cycle();
            wait_cnt++;
        end
        if (exp_q.size() != 0)
        begin
            err_cnt++;
            $display("timeout: %0d packets never reached D", exp_q.size());
            exp_q.delete();
        end
        repeat (2) next_cycle();
    endtask

    task automatic start_test();
        err_mark = err_cnt;
        test_cnt++;
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == err_mark)
            $display("test %0d %s: ok", test_cnt, name);
        else
        begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
        end
    endtask

    // ------------------------------------------------------------
    // A and D models
    // ------------------------------------------------------------
    always @(posedge clk)
    begin : drive_models
        logic hold_a;
        logic rand_a;
        logic rand_d;
        logic rsp_on;
        int   rnd;
        int   pick;
        // controls are taken at the edge and outputs driven just after it
        hold_a = a_rdy_hold;
        rand_a = a_rdy_rand;
        rand_d = d_rdy_rand;
        rsp_on = a_rsp_en;
        #2;
        rnd  = $random(seed);
        pick = -1;
        a2c_lkp_rsp_vld_i = 1'b0;
        a2c_lkp_rdy_i     = hold_a ? 1'b0 : (rand_a ? rnd[0] : 1'b1);
        d2c_pkt_rdy_i     = rand_d ? rnd[1] : 1'b1;
        // oldest request whose delay ran out is answered
        for (int k = 0; k < pend_dly.size(); k++)
        begin
            if (pend_dly[k] > 0)
                pend_dly[k]--;
            else if (pick < 0)
                pick = k;
        end
        if (rsp_on && pick >= 0)
        begin
            a2c_lkp_rsp_vld_i = 1'b1;
            a2c_lkp_rsp_id_i  = pend_id[pick];
            a2c_lkp_rslt_i    = pend_info[pick] ^ RSLT_KEY;
            pend_id.delete(pick);
            pend_info.delete(pick);
            pend_dly.delete(pick);
        end
    end

    // sampled mid-cycle ahead of the transfer edge
    always @(negedge clk)
    begin : watch_ports
        out_pkt_t got;
        int       rnd;
        if (!rst_i)
        begin
            got = '{c2d_pkt_lkp_rslt_o, c2d_pkt_odr_id_o, c2d_pkt_so_o, c2d_pkt_payload_o};
            if (a_held)
            begin
                check_flag(c2a_lkp_vld_o, 1'b1, "held request valid");
                check_rslt(c2a_lkp_info_o, a_held_req.info, "held request info");
                check_req_id(c2a_lkp_req_id_o, a_held_req.req_id, "held request id");
            end
            a_held            = c2a_lkp_vld_o && !a2c_lkp_rdy_i;
            a_held_req.info   = c2a_lkp_info_o;
            a_held_req.req_id = c2a_lkp_req_id_o;
            if (c2a_lkp_vld_o && a2c_lkp_rdy_i)
            begin
                rnd = $random(seed);
                a_req_cnt++;
                pend_info.push_back(c2a_lkp_info_o);
                pend_id.push_back(c2a_lkp_req_id_o);
                pend_dly.push_back((rnd & 15) + 1);
            end
            if (d_held)
            begin
                check_flag(c2d_pkt_vld_o, 1'b1, "held packet valid");
                compare_pkt(got, d_held_pkt);
            end
            d_held     = c2d_pkt_vld_o && !d2c_pkt_rdy_i;
            d_held_pkt = got;
            if (c2d_pkt_vld_o && d2c_pkt_rdy_i)
            begin
                d_cnt++;
                if (exp_q.size() == 0)
                begin
                    err_cnt++;
                    $display("packet with order id %0d reached D with none expected", got.odr_id);
                end
                else
                    compare_pkt(got, exp_q.pop_front());
            end
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial
    begin
        int req_mark;
        int d_mark;
        int wait_cnt;
        repeat (2) @(posedge clk);
        #2;
        rst_i = 1'b0;
        next_cycle();

        start_test();
        req_mark = a_req_cnt;
        run_rows(0, NUM_ROWS);
        wait_drain();
        check_flag(a_req_cnt == req_mark, 1'b1, "no request for bypass packets");
        finish_test("bypass");

        start_test();
        run_rows(1, NUM_ROWS);
        wait_drain();
        finish_test("lookup out of order");

        start_test();
        run_rows(2, NUM_ROWS);
        wait_drain();
        finish_test("mixed back to back");

        start_test();
        d_mark     = d_cnt;
        d_rdy_rand = 1'b1;
        a_rdy_rand = 1'b1;
        run_rows(2, NUM_ROWS);
        wait_drain();
        d_rdy_rand = 1'b0;
        a_rdy_rand = 1'b0;
        check_flag(d_cnt - d_mark == NUM_ROWS, 1'b1, "packet count at D");
        finish_test("random back-pressure");

        start_test();
        a_rdy_hold = 1'b1;
        run_rows(1, 3);
        repeat (6) next_cycle();
        @(negedge clk);
        check_flag(c2a_lkp_vld_o, 1'b1, "request valid while A not ready");
        a_rdy_hold = 1'b0;
        next_cycle();
        wait_drain();
        finish_test("A requests held");

        // no answers, so eight lookups fill the buffer
        start_test();
        a_rsp_en = 1'b0;
        d_mark   = d_cnt;
        run_rows(1, ROB_DEPTH);
        repeat (3) next_cycle();
        @(negedge clk);
        check_flag(c2b_pkt_rdy_o, 1'b0, "B ready with a full buffer");
        check_flag(d_cnt == d_mark, 1'b1, "no packet at D without responses");
        a_rsp_en = 1'b1;
        wait_cnt = 0;
        while (!c2b_pkt_rdy_o && wait_cnt < WAIT_LIMIT)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!c2b_pkt_rdy_o)
        begin
            err_cnt++;
            $display("timeout: B ready never rose after responses resumed");
        end
        next_cycle();
        wait_drain();
        finish_test("full buffer");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* tb.f */
common/pkt_lkp_pkg.sv
rtl/lkp_req_fifo.sv
rob/payload_ram.sv
rob/rob_ctrl.sv
rtl/pkt_egress.sv
rtl/pkt_lkp_top.sv
verif/tb_pkt_lkp.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it and search the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_pkt_lkp -f tb.f -o tb_pkt_lkp_sim \
    && ./obj_dir/tb_pkt_lkp_sim > sim.log 2>&1 \
    || echo "build or run of the simulation failed" >> sim.log
cat sim.log
grep -q "^\*\*\* TEST PASSED \*\*\*$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
